// File: Bender.yml
package:
  name: prf

export_include_dirs:
  - include

sources:
  - source/prf_pkg.sv
  - source/prf_bank_ram.sv
  - source/prf_read_arbiter.sv
  - source/prf_writeback_arbiter.sv
  - source/prf.sv
  - target: test
    files:
      - verification/prf_tb.sv

// File: include/prf_params.svh
`ifndef PRF_PARAMS_SVH
`define PRF_PARAMS_SVH

// low bits of a register number pick the bank
`define PRF_BANK_COUNT 4
`define PRF_LOG_BANK_COUNT 2

// physical register space
`define PRF_PR_COUNT 64
`define PRF_LOG_PR_COUNT 6

// requesters on each side
`define PRF_RR_COUNT 4
`define PRF_WR_COUNT 4

// register width
`define PRF_DATA_WIDTH 32

// ROB tag carried on the writeback bus
`define PRF_LOG_ROB_ENTRIES 6

`endif

// File: source/prf.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_params.svh"

module prf import prf_pkg::*; (
    input  wire logic CLK,
    input  wire logic nRST,

    // strobed read requests
    input  wire prf_read_req_t [`PRF_RR_COUNT-1:0] rd_req,
    output logic [`PRF_RR_COUNT-1:0] rd_ack,
    output logic [`PRF_RR_COUNT-1:0] rd_port,

    // read data by bank and port a cycle after the ack
    output prf_data_t [`PRF_BANK_COUNT-1:0][1:0] rd_data,

    // writebacks with back-pressure
    input  wire prf_wb_req_t [`PRF_WR_COUNT-1:0] wb_req,
    output logic [`PRF_WR_COUNT-1:0] wb_ready,

    // one registered bus per bank to wakeup
    output prf_wb_bus_t [`PRF_BANK_COUNT-1:0] wb_bus
);

    // granted read indices that each RAM registers
    prf_upper_pr_t [`PRF_BANK_COUNT-1:0][1:0] rd_index_next;

    // --------------------
    // arbitration

    prf_read_arbiter u_read_arb (
        .CLK           (CLK),
        .nRST          (nRST),
        .rd_req        (rd_req),
        .rd_ack        (rd_ack),
        .rd_port       (rd_port),
        .rd_index_next (rd_index_next)
    );

    // same bus word feeds wakeup and the array write
    prf_writeback_arbiter u_wb_arb (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb_req   (wb_req),
        .wb_ready (wb_ready),
        .wb_bus   (wb_bus)
    );

    // --------------------
    // one RAM per bank

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
        prf_bank_ram u_ram (
            .CLK           (CLK),
            .nRST          (nRST),
            .rd_index_next (rd_index_next[b]),
            .rd_data       (rd_data[b]),
            .wr            (wb_bus[b])
        );
    end

endmodule

`default_nettype wire

// File: source/prf_bank_ram.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_params.svh"

module prf_bank_ram import prf_pkg::*; (
    input  wire logic CLK,
    input  wire logic nRST,
    input  wire prf_upper_pr_t [1:0] rd_index_next,
    output prf_data_t [1:0] rd_data,
    input  wire prf_wb_bus_t wr
);

    // registers held by one bank
    localparam int DEPTH = `PRF_PR_COUNT / `PRF_BANK_COUNT;

    prf_data_t mem_q [DEPTH];
    prf_upper_pr_t [1:0] rd_index_q;

    // --------------------
    // read side

    // indices land one cycle after the grant
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_index_q <= '0;
        end else begin
            rd_index_q <= rd_index_next;
        end
    end

    // async read off the registered index
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_data[p] = mem_q[rd_index_q[p]];
        end
    end

    // --------------------
    // write side

    // bus cycle commits at its closing edge
    // so a read granted in that cycle sees the new value
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr.valid) begin
            mem_q[wr.upper] <= wr.data;
        end
    end

endmodule

`default_nettype wire

// File: source/prf_pkg.sv
`default_nettype none
`include "prf_params.svh"

package prf_pkg;

    // --------------------
    // basic fields
    typedef logic [`PRF_DATA_WIDTH-1:0] prf_data_t;
    typedef logic [`PRF_LOG_PR_COUNT-`PRF_LOG_BANK_COUNT-1:0] prf_upper_pr_t;
    typedef logic [`PRF_LOG_ROB_ENTRIES-1:0] prf_rob_index_t;

    // register number seen whole or as upper index + bank
    typedef union packed {
        logic [`PRF_LOG_PR_COUNT-1:0] raw;
        struct packed {
            prf_upper_pr_t upper;
            logic [`PRF_LOG_BANK_COUNT-1:0] bank;
        } split;
    } prf_pr_t;

    // --------------------
    // request and bus words
    typedef struct packed {
        logic valid;
        prf_pr_t pr;
    } prf_read_req_t;

    typedef struct packed {
        logic valid;
        prf_data_t data;
        prf_pr_t pr;
        prf_rob_index_t rob_index;
    } prf_wb_req_t;

    // per bank writeback word that also writes the RAM
    typedef struct packed {
        logic valid;
        prf_data_t data;
        prf_upper_pr_t upper;
        prf_rob_index_t rob_index;
    } prf_wb_bus_t;

    // --------------------
    // round-robin pick sized for either requester set
    localparam int PRF_PICK_WIDTH =
        (`PRF_RR_COUNT > `PRF_WR_COUNT) ? `PRF_RR_COUNT : `PRF_WR_COUNT;
    typedef logic [PRF_PICK_WIDTH-1:0] prf_pick_vec_t;

    function automatic prf_pick_vec_t prf_pick(input prf_pick_vec_t req,
                                               input prf_pick_vec_t mask);
        prf_pick_vec_t pool;
        prf_pick_vec_t win;
        // masked requests first and everyone otherwise
        if (|(req & mask)) begin
            pool = req & mask;
        end else begin
            pool = req;
        end
        // walk upward so the highest index has the last word
        win = '0;
        for (int i = 0; i < PRF_PICK_WIDTH; i++) begin
            if (pool[i]) begin
                win = '0;
                win[i] = 1'b1;
            end
        end
        return win;
    endfunction

endpackage

`default_nettype wire

// File: source/prf_read_arbiter.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_params.svh"

module prf_read_arbiter import prf_pkg::*; (
    input  wire logic CLK,
    input  wire logic nRST,
    input  wire prf_read_req_t [`PRF_RR_COUNT-1:0] rd_req,
    output logic [`PRF_RR_COUNT-1:0] rd_ack,
    output logic [`PRF_RR_COUNT-1:0] rd_port,
    output prf_upper_pr_t [`PRF_BANK_COUNT-1:0][1:0] rd_index_next
);

    // one held request per requester
    prf_read_req_t [`PRF_RR_COUNT-1:0] held_q;
    prf_read_req_t [`PRF_RR_COUNT-1:0] held_next;
    prf_read_req_t [`PRF_RR_COUNT-1:0] merged;

    // per bank request and grant vectors
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] req_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] grant0;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] grant1;

    // round-robin state, one mask per bank
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] mask_q;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] mask_next;

    // --------------------
    // merge and steer

    // held request wins over a new strobe
    always_comb begin
        for (int i = 0; i < `PRF_RR_COUNT; i++) begin
            if (held_q[i].valid) begin
                merged[i] = held_q[i];
            end else begin
                merged[i] = rd_req[i];
            end
        end
    end

    // demux to banks by the low register bits
    always_comb begin
        req_by_bank = '0;
        for (int i = 0; i < `PRF_RR_COUNT; i++) begin
            req_by_bank[merged[i].pr.split.bank][i] = merged[i].valid;
        end
    end

    // --------------------
    // two port grants per bank

    always_comb begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            // port 0 over all requests
            grant0[b] = (`PRF_RR_COUNT)'(prf_pick(prf_pick_vec_t'(req_by_bank[b]),
                                                  prf_pick_vec_t'(mask_q[b])));
            // port 1 with port 0's winner taken out
            grant1[b] = (`PRF_RR_COUNT)'(
                prf_pick(prf_pick_vec_t'(req_by_bank[b] & ~grant0[b]),
                         prf_pick_vec_t'(mask_q[b])));
            // mask = everything below the last winner
            // one-hot minus one gives exactly that
            if (|grant1[b]) begin
                mask_next[b] = grant1[b] - 1'b1;
            end else if (|grant0[b]) begin
                mask_next[b] = grant0[b] - 1'b1;
            end else begin
                mask_next[b] = mask_q[b];
            end
        end
    end

    // fold bank grants back onto requesters
    always_comb begin
        rd_ack = '0;
        rd_port = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            rd_ack |= grant0[b] | grant1[b];
            rd_port |= grant1[b];
        end
    end

    // one-hot mux of winning upper indices
    // zero index when a port is idle
    always_comb begin
        rd_index_next = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            for (int i = 0; i < `PRF_RR_COUNT; i++) begin
                rd_index_next[b][0] |= merged[i].pr.split.upper
                                       & {$bits(prf_upper_pr_t){grant0[b][i]}};
                rd_index_next[b][1] |= merged[i].pr.split.upper
                                       & {$bits(prf_upper_pr_t){grant1[b][i]}};
            end
        end
    end

    // --------------------
    // hold losers

    always_comb begin
        for (int i = 0; i < `PRF_RR_COUNT; i++) begin
            held_next[i].valid = merged[i].valid & ~rd_ack[i];
            held_next[i].pr = merged[i].pr;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_q <= '0;
            mask_q <= '0;
        end else begin
            held_q <= held_next;
            mask_q <= mask_next;
        end
    end

endmodule

`default_nettype wire

// File: source/prf_writeback_arbiter.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_params.svh"

module prf_writeback_arbiter import prf_pkg::*; (
    input  wire logic CLK,
    input  wire logic nRST,
    input  wire prf_wb_req_t [`PRF_WR_COUNT-1:0] wb_req,
    output logic [`PRF_WR_COUNT-1:0] wb_ready,
    output prf_wb_bus_t [`PRF_BANK_COUNT-1:0] wb_bus
);

    // one-entry retry hold per writer
    prf_wb_req_t [`PRF_WR_COUNT-1:0] held_q;
    prf_wb_req_t [`PRF_WR_COUNT-1:0] held_next;
    prf_wb_req_t [`PRF_WR_COUNT-1:0] merged;

    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] req_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] grant;
    logic [`PRF_WR_COUNT-1:0] ack;

    // per bank round-robin mask
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] mask_q;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] mask_next;

    prf_wb_bus_t [`PRF_BANK_COUNT-1:0] bus_next;

    // --------------------
    // merge, steer, ready

    // stall only a writer that already has one held
    // new write must stay on the port that cycle
    always_comb begin
        for (int i = 0; i < `PRF_WR_COUNT; i++) begin
            wb_ready[i] = ~(wb_req[i].valid & held_q[i].valid);
        end
    end

    always_comb begin
        req_by_bank = '0;
        for (int i = 0; i < `PRF_WR_COUNT; i++) begin
            // held write goes first
            merged[i] = held_q[i].valid ? held_q[i] : wb_req[i];
            req_by_bank[merged[i].pr.split.bank][i] = merged[i].valid;
        end
    end

    // --------------------
    // one grant per bank

    always_comb begin
        ack = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            grant[b] = (`PRF_WR_COUNT)'(prf_pick(prf_pick_vec_t'(req_by_bank[b]),
                                                 prf_pick_vec_t'(mask_q[b])));
            ack |= grant[b];
            // idle bank keeps its mask
            if (|grant[b]) begin
                mask_next[b] = grant[b] - 1'b1;
            end else begin
                mask_next[b] = mask_q[b];
            end
        end
    end

    // one-hot mux of the winner onto the bus
    always_comb begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            bus_next[b] = '0;
            bus_next[b].valid = |grant[b];
            for (int i = 0; i < `PRF_WR_COUNT; i++) begin
                bus_next[b].data |= merged[i].data
                                    & {`PRF_DATA_WIDTH{grant[b][i]}};
                bus_next[b].upper |= merged[i].pr.split.upper
                                     & {$bits(prf_upper_pr_t){grant[b][i]}};
                bus_next[b].rob_index |= merged[i].rob_index
                                         & {`PRF_LOG_ROB_ENTRIES{grant[b][i]}};
            end
        end
    end

    // losers stay held with the merged payload
    always_comb begin
        for (int i = 0; i < `PRF_WR_COUNT; i++) begin
            held_next[i] = merged[i];
            held_next[i].valid = merged[i].valid & ~ack[i];
        end
    end

    // --------------------
    // state

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_q <= '0;
            mask_q <= '0;
            wb_bus <= '0;
        end else begin
            held_q <= held_next;
            mask_q <= mask_next;
            wb_bus <= bus_next;
        end
    end

endmodule

`default_nettype wire

// File: verification/prf_stim.txt
// op req pr data rob expect, all hex, one line per operation
// op 1 stage write, 2 stage read, 3 issue staged, 4 burst to pr's bank, 0 end
2 0 05 00000000 00 00000000
3 0 00 00000000 00 00000001
1 1 0e a5a51234 11 00000000
3 0 00 00000000 00 00000020
2 0 0e 00000000 00 a5a51234
3 0 00 00000000 00 00000001
1 0 03 3c3c0003 20 00000000
1 1 07 3c3c0007 21 00000000
1 2 0b 3c3c000b 22 00000000
1 3 0f 3c3c000f 23 00000000
3 0 00 00000000 00 00000080
2 0 03 00000000 00 3c3c0003
2 1 07 00000000 00 3c3c0007
2 2 0b 00000000 00 3c3c000b
2 3 0f 00000000 00 3c3c000f
3 0 00 00000000 00 0000030c
4 0 00 00000000 00 00000000
1 0 24 5a5a0024 30 00000000
1 1 25 5a5a0025 31 00000000
1 2 26 5a5a0026 32 00000000
1 3 27 5a5a0027 33 00000000
2 0 0e 00000000 00 a5a51234
2 1 0f 00000000 00 3c3c000f
2 2 05 00000000 00 00000000
2 3 30 00000000 00 00000000
3 0 00 00000000 00 000000ff
2 0 24 00000000 00 5a5a0024
2 1 25 00000000 00 5a5a0025
2 2 26 00000000 00 5a5a0026
2 3 27 00000000 00 5a5a0027
3 0 00 00000000 00 0000000f
0 0 00 00000000 00 00000000

// File: verification/prf_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_params.svh"

module prf_tb import prf_pkg::*; ();

    localparam int NR = `PRF_RR_COUNT;
    localparam int NW = `PRF_WR_COUNT;
    localparam int NB = `PRF_BANK_COUNT;
    localparam int STIM_ROWS = 64;
    localparam int DRAIN_LIMIT = 40;

    logic CLK;
    logic nRST;
    prf_read_req_t [NR-1:0] rd_req;
    logic [NR-1:0] rd_ack;
    logic [NR-1:0] rd_port;
    prf_data_t [NB-1:0][1:0] rd_data;
    prf_wb_req_t [NW-1:0] wb_req;
    logic [NW-1:0] wb_ready;
    prf_wb_bus_t [NB-1:0] wb_bus;

    prf u_prf (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_req   (rd_req),
        .rd_ack   (rd_ack),
        .rd_port  (rd_port),
        .rd_data  (rd_data),
        .wb_req   (wb_req),
        .wb_ready (wb_ready),
        .wb_bus   (wb_bus)
    );

    // six words per stim row
    logic [31:0] stim [STIM_ROWS*6];
    int seed = 34790;
    int errors;
    int checks;

    // inputs for the next rising edge
    prf_read_req_t [NR-1:0] rd_next;
    prf_data_t rd_exp_next [NR];
    prf_wb_req_t [NW-1:0] wb_next;

    // strobed reads still waiting for an ack
    prf_read_req_t rd_wait [NR];
    prf_data_t rd_wait_exp [NR];

    // read data due one cycle after the ack
    logic chk_valid [NR];
    int chk_bank [NR];
    int chk_port [NR];
    prf_data_t chk_exp [NR];

    // accepted writes not yet on the bus
    // ready keeps this to one per writer
    prf_wb_req_t acc [NW];
    prf_data_t shadow [`PRF_PR_COUNT];

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic clear_pending();
        for (int i = 0; i < NR; i++) begin
            rd_wait[i] = '0;
            chk_valid[i] = 1'b0;
        end
        for (int i = 0; i < NW; i++) begin
            acc[i] = '0;
        end
        rd_next = '0;
        wb_next = '0;
    endtask

    function automatic logic pending_work();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < NR; i++) begin
            busy |= rd_wait[i].valid | chk_valid[i];
        end
        for (int i = 0; i < NW; i++) begin
            busy |= acc[i].valid | wb_next[i].valid;
        end
        return busy;
    endfunction

    // --------------------
    // one clock of traffic
    // drive at the rising edge and sample at the falling edge
    task automatic run_cycle(output logic [NR-1:0] acks, output logic [NW-1:0] bus_from);
        logic found;
        logic exp_ready;
        @(posedge CLK);
        rd_req <= rd_next;
        wb_req <= wb_next;
        @(negedge CLK);
        bus_from = '0;
        // data for last cycle's acks
        for (int i = 0; i < NR; i++) begin
            if (chk_valid[i]) begin
                check_value("rd_data", rd_data[chk_bank[i]][chk_port[i]], chk_exp[i]);
                chk_valid[i] = 1'b0;
            end
        end
        // each bus entry must retire one accepted write
        for (int b = 0; b < NB; b++) begin
            if (wb_bus[b].valid) begin
                found = 1'b0;
                for (int i = 0; i < NW; i++) begin
                    if (!found && acc[i].valid && acc[i].pr.split.bank == b
                        && acc[i].pr.split.upper == wb_bus[b].upper) begin
                        found = 1'b1;
                        check_value("wb_bus.data", wb_bus[b].data, acc[i].data);
                        check_value("wb_bus.rob_index", wb_bus[b].rob_index,
                                    acc[i].rob_index);
                        acc[i].valid = 1'b0;
                        bus_from[i] = 1'b1;
                    end
                end
                if (!found) begin
                    errors++;
                    $display("bank %0d showed a writeback that no writer is owed", b);
                end
            end
        end
        // ready low only with a write still held
        for (int i = 0; i < NW; i++) begin
            exp_ready = !(wb_next[i].valid && acc[i].valid);
            check_value("wb_ready", wb_ready[i], exp_ready);
            if (wb_next[i].valid && wb_ready[i]) begin
                acc[i] = wb_next[i];
                shadow[wb_next[i].pr.raw] = wb_next[i].data;
                wb_next[i].valid = 1'b0;
            end
        end
        // record new strobes before taking this cycle's acks
        for (int i = 0; i < NR; i++) begin
            if (rd_next[i].valid) begin
                rd_wait[i] = rd_next[i];
                rd_wait_exp[i] = rd_exp_next[i];
            end
            if (rd_ack[i] && !rd_wait[i].valid) begin
                errors++;
                $display("requester %0d got a read ack without a request", i);
            end else if (rd_ack[i]) begin
                chk_valid[i] = 1'b1;
                chk_bank[i] = rd_wait[i].pr.split.bank;
                chk_port[i] = rd_port[i];
                chk_exp[i] = rd_wait_exp[i];
                rd_wait[i].valid = 1'b0;
            end
        end
        // two reads in one bank and cycle need both ports
        for (int i = 0; i < NR; i++) begin
            for (int j = i + 1; j < NR; j++) begin
                if (rd_ack[i] && rd_ack[j] && chk_bank[i] == chk_bank[j]
                    && rd_port[i] == rd_port[j]) begin
                    errors++;
                    $display("requesters %0d and %0d were given the same read port", i, j);
                end
            end
        end
        acks = rd_ack;
        rd_next = '0;
    endtask

    // run until nothing is owed or the limit runs out
    task automatic drain();
        logic [NR-1:0] acks;
        logic [NW-1:0] seen;
        int n;
        n = 0;
        while (pending_work() && n < DRAIN_LIMIT) begin
            run_cycle(acks, seen);
            n++;
        end
        if (pending_work()) begin
            errors++;
            $display("timed out waiting for read acks, read data or writebacks");
            clear_pending();
        end
    endtask

    // expect bits 3:0 hold the first cycle's acks
    // bits 7:4 hold the writers seen on the bus a cycle later
    // bits 11:8 hold the acks of that later cycle
    task automatic issue_batch(input logic [31:0] expect_word);
        logic [NR-1:0] acks;
        logic [NW-1:0] seen;
        run_cycle(acks, seen);
        check_value("rd_ack", acks, expect_word[3:0]);
        run_cycle(acks, seen);
        check_value("wb_bus.valid by writer", seen, expect_word[7:4]);
        check_value("rd_ack next cycle", acks, expect_word[11:8]);
        drain();
    endtask

    // --------------------
    // two back-to-back random rounds into one bank and a full read back
    task automatic write_burst(input int bank);
        logic [NR-1:0] acks;
        logic [NW-1:0] seen;
        prf_pr_t pr;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < NW; i++) begin
                pr.split.upper = prf_upper_pr_t'(r * NW + i);
                pr.split.bank = bank[`PRF_LOG_BANK_COUNT-1:0];
                wb_next[i].valid = 1'b1;
                wb_next[i].data = $random(seed);
                wb_next[i].pr = pr;
                wb_next[i].rob_index = prf_rob_index_t'(r * NW + i);
            end
            run_cycle(acks, seen);
        end
        drain();
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < NR; i++) begin
                pr.split.upper = prf_upper_pr_t'(r * NR + i);
                pr.split.bank = bank[`PRF_LOG_BANK_COUNT-1:0];
                rd_next[i].valid = 1'b1;
                rd_next[i].pr = pr;
                rd_exp_next[i] = shadow[pr.raw];
            end
            run_cycle(acks, seen);
            drain();
        end
    endtask

    initial begin
        logic [31:0] op;
        logic done;
        int base;
        int req;
        int row;
        errors = 0;
        checks = 0;
        nRST = 1'b0;
        rd_req = '0;
        wb_req = '0;
        clear_pending();
        $readmemh("verification/prf_stim.txt", stim);
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        done = 1'b0;
        row = 0;
        while (!done && row < STIM_ROWS) begin
            base = row * 6;
            op = stim[base];
            req = stim[base+1];
            case (op)
                0: done = 1'b1;
                1: begin
                    wb_next[req].valid = 1'b1;
                    wb_next[req].pr.raw = stim[base+2][`PRF_LOG_PR_COUNT-1:0];
                    wb_next[req].data = stim[base+3];
                    wb_next[req].rob_index = stim[base+4][`PRF_LOG_ROB_ENTRIES-1:0];
                end
                2: begin
                    rd_next[req].valid = 1'b1;
                    rd_next[req].pr.raw = stim[base+2][`PRF_LOG_PR_COUNT-1:0];
                    rd_exp_next[req] = stim[base+5];
                end
                3: issue_batch(stim[base+5]);
                4: write_burst(stim[base+2][`PRF_LOG_BANK_COUNT-1:0]);
                default: begin
                    errors++;
                    $display("stim row %0d has an unknown operation", row);
                    done = 1'b1;
                end
            endcase
            row++;
        end
        if (!done) begin
            errors++;
            $display("stim file ran out without an end row");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
source/prf_pkg.sv
source/prf_bank_ram.sv
source/prf_read_arbiter.sv
source/prf_writeback_arbiter.sv
source/prf.sv
verification/prf_tb.sv
